//--- source/proc_pkg.sv
package proc_pkg;

	// data path and register width
	localparam int data_w = 12;
	// instruction and data memory address width
	localparam int addr_w = 12;
	// full instruction word
	localparam int instr_w = 17;
	// opcode sits in the top bits of the word
	localparam int opcode_w = 5;

	// instruction field positions
	localparam int opcode_msb = instr_w - 1;
	localparam int opcode_lsb = instr_w - opcode_w;
	localparam int operand_msb = opcode_lsb - 1;

	// general registers r1 to r4, picked by low operand bits
	localparam int num_regs = 4;
	localparam int reg_idx_w = 2;

	typedef enum logic [opcode_w-1:0] {
		NOP, LDI, LDA, STA, MOVR,
		ADDR, SUBR, ANDR, ORR, XORR,
		INCA, CLRA, JMP, JZ, HALT
	} opcode_t;

	// one instruction is fetch, decode, exec
	typedef enum logic [1:0] {
		FETCH, DECODE, EXEC, HALTED
	} state_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS
	} alu_op_t;

	// register sources must stay first, in index order
	typedef enum logic [2:0] {
		SRC_R1, SRC_R2, SRC_R3, SRC_R4, SRC_AC, SRC_IMM, SRC_DM
	} bus_src_t;

endpackage

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [proc_pkg::data_w-1:0] a,
	input  logic [proc_pkg::data_w-1:0] b,
	input  proc_pkg::alu_op_t           alu_op,
	output logic [proc_pkg::data_w-1:0] y
);
	import proc_pkg::*;

	// a is the accumulator, b the bus
	always_comb begin
		case (alu_op)
			// carry out dropped
			ALU_ADD: begin
				y = a + b;
			end
			// a minus b, borrow dropped
			ALU_SUB: begin
				y = a - b;
			end
			ALU_AND: begin
				y = a & b;
			end
			ALU_OR: begin
				y = a | b;
			end
			ALU_XOR: begin
				y = a ^ b;
			end
			// pass and any unused code hand b through
			default: begin
				y = b;
			end
		endcase
	end

endmodule

//--- source/operand_bus.sv
`timescale 1ns/1ps

module operand_bus (
	input  proc_pkg::bus_src_t          bus_sel,
	input  logic [proc_pkg::data_w-1:0] r1,
	input  logic [proc_pkg::data_w-1:0] r2,
	input  logic [proc_pkg::data_w-1:0] r3,
	input  logic [proc_pkg::data_w-1:0] r4,
	input  logic [proc_pkg::data_w-1:0] ac,
	input  logic [proc_pkg::data_w-1:0] imm,
	input  logic [proc_pkg::data_w-1:0] dm_out,
	output logic [proc_pkg::data_w-1:0] bus
);
	import proc_pkg::*;

	// one source at a time, no latency
	always_comb begin
		case (bus_sel)
			SRC_R1:  bus = r1;
			SRC_R2:  bus = r2;
			SRC_R3:  bus = r3;
			SRC_R4:  bus = r4;
			SRC_AC:  bus = ac;
			// operand field of the ir
			SRC_IMM: bus = imm;
			// data memory read at ar
			SRC_DM:  bus = dm_out;
			default: bus = '0;
		endcase
	end

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [proc_pkg::num_regs-1:0] reg_we,
	input  logic [proc_pkg::data_w-1:0]   bus,
	output logic [proc_pkg::data_w-1:0]   r1,
	output logic [proc_pkg::data_w-1:0]   r2,
	output logic [proc_pkg::data_w-1:0]   r3,
	output logic [proc_pkg::data_w-1:0]   r4
);
	import proc_pkg::*;

	logic [data_w-1:0] regs [num_regs];

	// bit 0 of reg_we is r1
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < num_regs; i++) begin
				if (reg_we[i]) begin
					regs[i] <= bus;
				end
			end
		end
	end

	assign r1 = regs[0];
	assign r2 = regs[1];
	assign r3 = regs[2];
	assign r4 = regs[3];

endmodule

//--- source/acc_unit.sv
`timescale 1ns/1ps

module acc_unit (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [proc_pkg::data_w-1:0] bus,
	input  logic [proc_pkg::data_w-1:0] alu_out,
	input  logic                        ac_load,
	input  logic                        ac_alu,
	input  logic                        ac_inc,
	input  logic                        ac_clr,
	output logic [proc_pkg::data_w-1:0] ac,
	output logic                        zero
);
	import proc_pkg::*;

	logic [data_w-1:0] ac_next;
	logic ac_we;

	// clear wins, then inc, then alu, then bus
	always_comb begin
		ac_we = ac_clr | ac_inc | ac_alu | ac_load;
		if (ac_clr) begin
			ac_next = '0;
		end else if (ac_inc) begin
			// wraps at 4096
			ac_next = ac + data_w'(1);
		end else if (ac_alu) begin
			ac_next = alu_out;
		end else begin
			ac_next = bus;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ac <= '0;
			// ac is zero out of reset, so the flag is set
			zero <= 1'b1;
		end else if (ac_we) begin
			ac <= ac_next;
			// flag follows the value being written
			zero <= (ac_next == '0);
		end
	end

endmodule

//--- source/addr_regs.sv
`timescale 1ns/1ps

module addr_regs (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [proc_pkg::instr_w-1:0] im_out,
	input  logic                         ir_load,
	input  logic                         pc_inc,
	input  logic                         pc_load,
	input  logic                         ar_load,
	output logic [proc_pkg::addr_w-1:0]  pc_out,
	output logic [proc_pkg::addr_w-1:0]  ar_out,
	output proc_pkg::opcode_t            opcode,
	output logic [proc_pkg::data_w-1:0]  operand
);
	import proc_pkg::*;

	logic [instr_w-1:0] ir;

	// jump target comes from ar, load beats increment
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_out <= '0;
		end else if (pc_load) begin
			pc_out <= ar_out;
		end else if (pc_inc) begin
			pc_out <= pc_out + addr_w'(1);
		end
	end

	// ar latches the operand field during decode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ar_out <= '0;
		end else if (ar_load) begin
			ar_out <= ir[operand_msb:0];
		end
	end

	// straight from instruction memory
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ir <= '0;
		end else if (ir_load) begin
			ir <= im_out;
		end
	end

	// codes past halt decode as no-ops in control
	assign opcode = opcode_t'(ir[opcode_msb:opcode_lsb]);
	assign operand = ir[operand_msb:0];

endmodule

//--- source/control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  logic                             clk,
	input  logic                             rst_n,
	input  proc_pkg::opcode_t                opcode,
	input  logic [proc_pkg::reg_idx_w-1:0]   operand_lo,
	input  logic                             zero,
	output proc_pkg::bus_src_t               bus_sel,
	output proc_pkg::alu_op_t                alu_op,
	output logic [proc_pkg::num_regs-1:0]    reg_we,
	output logic                             ac_load,
	output logic                             ac_alu,
	output logic                             ac_inc,
	output logic                             ac_clr,
	output logic                             ir_load,
	output logic                             pc_inc,
	output logic                             pc_load,
	output logic                             ar_load,
	output logic                             dm_en,
	output logic                             end_process
);
	import proc_pkg::*;

	state_t state;
	state_t state_next;

	// register index from the operand field
	bus_src_t reg_src;
	logic [num_regs-1:0] reg_onehot;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FETCH;
		end else begin
			state <= state_next;
		end
	end

	// fixed three-cycle sequence, halt is sticky
	always_comb begin
		case (state)
			FETCH:   state_next = DECODE;
			DECODE:  state_next = EXEC;
			EXEC:    state_next = (opcode == HALT) ? HALTED : FETCH;
			default: state_next = HALTED;
		endcase
	end

	// index 0 is r1
	always_comb begin
		reg_onehot = '0;
		reg_onehot[operand_lo] = 1'b1;
		case (operand_lo)
			2'd0:    reg_src = SRC_R1;
			2'd1:    reg_src = SRC_R2;
			2'd2:    reg_src = SRC_R3;
			default: reg_src = SRC_R4;
		endcase
	end

	always_comb begin
		// everything idle unless the state says otherwise
		bus_sel = SRC_AC;
		alu_op = ALU_PASS;
		reg_we = '0;
		ac_load = 1'b0;
		ac_alu = 1'b0;
		ac_inc = 1'b0;
		ac_clr = 1'b0;
		ir_load = 1'b0;
		pc_inc = 1'b0;
		pc_load = 1'b0;
		ar_load = 1'b0;
		dm_en = 1'b0;
		end_process = 1'b0;
		case (state)
			// ir takes im_out, pc moves on
			FETCH: begin
				ir_load = 1'b1;
				pc_inc = 1'b1;
			end
			// ar takes the operand field
			DECODE: begin
				ar_load = 1'b1;
			end
			EXEC: begin
				case (opcode)
					LDI: begin
						bus_sel = SRC_IMM;
						ac_load = 1'b1;
					end
					// dm_out is addressed by ar
					LDA: begin
						bus_sel = SRC_DM;
						ac_load = 1'b1;
					end
					// one write strobe, ac on the bus
					STA: begin
						bus_sel = SRC_AC;
						dm_en = 1'b1;
					end
					// ac copied into the chosen register
					MOVR: begin
						bus_sel = SRC_AC;
						reg_we = reg_onehot;
					end
					ADDR: begin
						bus_sel = reg_src;
						alu_op = ALU_ADD;
						ac_alu = 1'b1;
					end
					SUBR: begin
						bus_sel = reg_src;
						alu_op = ALU_SUB;
						ac_alu = 1'b1;
					end
					ANDR: begin
						bus_sel = reg_src;
						alu_op = ALU_AND;
						ac_alu = 1'b1;
					end
					ORR: begin
						bus_sel = reg_src;
						alu_op = ALU_OR;
						ac_alu = 1'b1;
					end
					XORR: begin
						bus_sel = reg_src;
						alu_op = ALU_XOR;
						ac_alu = 1'b1;
					end
					INCA: ac_inc = 1'b1;
					CLRA: ac_clr = 1'b1;
					// target already sits in ar
					JMP: pc_load = 1'b1;
					JZ: pc_load = zero;
					// nop, halt and unused codes do nothing here
					default: ;
				endcase
			end
			default: end_process = 1'b1;
		endcase
	end

endmodule

//--- source/proc_top.sv
`timescale 1ns/1ps

module proc_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [proc_pkg::instr_w-1:0] im_out,
	input  logic [proc_pkg::data_w-1:0]  dm_out,
	output logic [proc_pkg::addr_w-1:0]  pc_out,
	output logic [proc_pkg::addr_w-1:0]  ar_out,
	output logic [proc_pkg::data_w-1:0]  bus_out,
	output logic                        dm_en,
	output logic                        end_process
);
	import proc_pkg::*;

	// control to datapath
	bus_src_t bus_sel;
	alu_op_t alu_op;
	logic [num_regs-1:0] reg_we;
	logic ac_load;
	logic ac_alu;
	logic ac_inc;
	logic ac_clr;
	logic ir_load;
	logic pc_inc;
	logic pc_load;
	logic ar_load;

	// datapath back to control
	opcode_t opcode;
	logic [data_w-1:0] operand;
	logic zero;

	// register and alu values
	logic [data_w-1:0] r1;
	logic [data_w-1:0] r2;
	logic [data_w-1:0] r3;
	logic [data_w-1:0] r4;
	logic [data_w-1:0] ac;
	logic [data_w-1:0] alu_out;

	control_unit u_ctrl (
		.clk(clk), .rst_n(rst_n), .opcode(opcode),
		.operand_lo(operand[reg_idx_w-1:0]), .zero(zero),
		.bus_sel(bus_sel), .alu_op(alu_op), .reg_we(reg_we),
		.ac_load(ac_load), .ac_alu(ac_alu), .ac_inc(ac_inc), .ac_clr(ac_clr),
		.ir_load(ir_load), .pc_inc(pc_inc), .pc_load(pc_load), .ar_load(ar_load),
		.dm_en(dm_en), .end_process(end_process)
	);

	addr_regs u_addr (
		.clk(clk), .rst_n(rst_n), .im_out(im_out),
		.ir_load(ir_load), .pc_inc(pc_inc), .pc_load(pc_load), .ar_load(ar_load),
		.pc_out(pc_out), .ar_out(ar_out), .opcode(opcode), .operand(operand)
	);

	// r1 to r4 written from the bus
	reg_file u_regs (
		.clk(clk), .rst_n(rst_n), .reg_we(reg_we), .bus(bus_out),
		.r1(r1), .r2(r2), .r3(r3), .r4(r4)
	);

	acc_unit u_acc (
		.clk(clk), .rst_n(rst_n), .bus(bus_out), .alu_out(alu_out),
		.ac_load(ac_load), .ac_alu(ac_alu), .ac_inc(ac_inc), .ac_clr(ac_clr),
		.ac(ac), .zero(zero)
	);

	// accumulator against bus
	alu u_alu (.a(ac), .b(bus_out), .alu_op(alu_op), .y(alu_out));

	// operand field doubles as the immediate
	operand_bus u_bus (
		.bus_sel(bus_sel), .r1(r1), .r2(r2), .r3(r3), .r4(r4),
		.ac(ac), .imm(operand), .dm_out(dm_out), .bus(bus_out)
	);

endmodule

//--- tests/proc_ref.svh
`ifndef PROC_REF_SVH
`define PROC_REF_SVH

// unused words are halts whose operand is their own address
task automatic clear_program();
	for (int a = 0; a < mem_depth; a++) begin
		imem[addr_w'(a)] = {HALT, addr_w'(a)};
	end
	prog_len = 0;
endtask

// append one instruction at the next free address
task automatic emit(input opcode_t op, input logic [data_w-1:0] arg);
	imem[addr_w'(prog_len)] = {op, arg};
	prog_len++;
endtask

// same starting image for the dut memory and the model copy
task automatic fill_data();
	for (int a = 0; a < mem_depth; a++) begin
		init_dm[addr_w'(a)] = data_w'(a * 37 + 41);
		ref_dm[addr_w'(a)] = data_w'(a * 37 + 41);
	end
endtask

// instruction set model that returns the pc after halt
function automatic logic [addr_w-1:0] model_run();
	logic [addr_w-1:0] pc;
	logic [data_w-1:0] ac;
	logic [data_w-1:0] rf [4];
	logic [instr_w-1:0] ir;
	logic [data_w-1:0] arg;
	logic [1:0] idx;
	logic halted;
	int steps;
	pc = '0;
	ac = '0;
	rf = '{default: '0};
	halted = 1'b0;
	steps = 0;
	st_addr_q.delete();
	st_data_q.delete();
	// step bound guards against a looping program
	while (!halted && steps < mem_depth) begin
		ir = imem[pc];
		pc = pc + addr_w'(1);
		arg = ir[operand_msb:0];
		// low two operand bits pick r1 to r4
		idx = arg[1:0];
		steps++;
		case (opcode_t'(ir[opcode_msb:opcode_lsb]))
			LDI: ac = arg;
			LDA: ac = ref_dm[arg];
			// every store is queued in program order
			STA: begin
				ref_dm[arg] = ac;
				st_addr_q.push_back(arg);
				st_data_q.push_back(ac);
			end
			MOVR: rf[idx] = ac;
			ADDR: ac = ac + rf[idx];
			SUBR: ac = ac - rf[idx];
			ANDR: ac = ac & rf[idx];
			ORR: ac = ac | rf[idx];
			XORR: ac = ac ^ rf[idx];
			INCA: ac = ac + data_w'(1);
			CLRA: ac = '0;
			JMP: pc = arg;
			// zero flag always matches ac == 0
			JZ: pc = (ac == '0) ? arg : pc;
			HALT: halted = 1'b1;
			default: ;
		endcase
	end
	return pc;
endfunction

`endif

//--- tests/proc_tb.sv
`timescale 1ns/1ps

module proc_tb;
	import proc_pkg::*;

	localparam int mem_depth = 1 << addr_w;
	localparam int rst_cycles = 3;
	// reset 2, moves 11, alu 27, branch 14, random 41
	localparam int total_instr = 95;
	// three cycles per instruction, reset and settle per test, plus margin
	localparam int cycle_limit = 3 * total_instr + 5 * (rst_cycles + 4) + 200;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic [instr_w-1:0] im_out;
	logic [data_w-1:0] dm_out;
	logic [addr_w-1:0] pc_out;
	logic [addr_w-1:0] ar_out;
	logic [data_w-1:0] bus_out;
	logic dm_en;
	logic end_process;

	logic [instr_w-1:0] imem [mem_depth];
	logic [data_w-1:0] dmem [mem_depth];
	logic [data_w-1:0] init_dm [mem_depth];
	logic [data_w-1:0] ref_dm [mem_depth];
	// stores predicted by the model
	logic [addr_w-1:0] st_addr_q [$];
	logic [data_w-1:0] st_data_q [$];
	int prog_len;
	int seed = 32'h729f;
	int cycles = 0;
	int errs;
	int pass_cnt = 0;
	int fail_cnt = 0;

	`include "proc_ref.svh"

	proc_top dut (
		.clk(clk), .rst_n(rst_n), .im_out(im_out), .dm_out(dm_out),
		.pc_out(pc_out), .ar_out(ar_out), .bus_out(bus_out),
		.dm_en(dm_en), .end_process(end_process)
	);

	always #10 clk = ~clk;

	// both memories read combinationally
	assign im_out = imem[pc_out];
	assign dm_out = dmem[ar_out];

	// reload the image while in reset, else take strobed writes
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int a = 0; a < mem_depth; a++) begin
				dmem[addr_w'(a)] <= init_dm[addr_w'(a)];
			end
		end else if (dm_en) begin
			dmem[ar_out] <= bus_out;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("processor never halted within %0d cycles", cycle_limit);
			$display("sim failed");
			$finish;
		end
	end

	task automatic check_idle(input string name);
		if (dm_en !== 1'b0) begin
			$display("FAILED %s reset dm_en expected 0 actual %b", name, dm_en);
			errs++;
		end
		if (end_process !== 1'b0) begin
			$display("FAILED %s reset end_process expected 0 actual %b", name, end_process);
			errs++;
		end
		if (pc_out !== '0) begin
			$display("FAILED %s reset pc_out expected 000 actual %03h", name, pc_out);
			errs++;
		end
	endtask

	// address and data of a strobed write against the next predicted store
	task automatic check_store(input string name);
		logic [addr_w-1:0] exp_a;
		logic [data_w-1:0] exp_d;
		if (st_addr_q.size() == 0) begin
			$display("test %s wrote %03h at %03h where no store was expected",
				name, bus_out, ar_out);
			errs++;
		end else begin
			exp_a = st_addr_q.pop_front();
			exp_d = st_data_q.pop_front();
			if (ar_out !== exp_a || bus_out !== exp_d) begin
				$display("FAILED %s store expected %03h at %03h actual %03h at %03h",
					name, exp_d, exp_a, bus_out, ar_out);
				errs++;
			end
		end
	endtask

	task automatic run_test(input string name);
		logic [addr_w-1:0] exp_pc;
		errs = 0;
		fill_data();
		exp_pc = model_run();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (rst_cycles) begin
			@(negedge clk);
			check_idle(name);
			@(posedge clk);
		end
		rst_n <= 1'b1;
		// first fetch has not happened yet
		@(negedge clk);
		check_idle(name);
		while (end_process !== 1'b1) begin
			@(negedge clk);
			if (dm_en === 1'b1) begin
				check_store(name);
			end
		end
		// halt must still hold one cycle later
		@(negedge clk);
		for (int a = 0; a < mem_depth; a++) begin
			if (dmem[addr_w'(a)] !== ref_dm[addr_w'(a)]) begin
				$display("FAILED %s dm[%03h] expected %03h actual %03h",
					name, a, ref_dm[addr_w'(a)], dmem[addr_w'(a)]);
				errs++;
			end
		end
		if (st_addr_q.size() != 0) begin
			$display("test %s never made %0d predicted stores", name, st_addr_q.size());
			errs++;
		end
		if (end_process !== 1'b1) begin
			$display("FAILED %s end_process expected 1 actual %b", name, end_process);
			errs++;
		end
		if (pc_out !== exp_pc) begin
			$display("FAILED %s pc_out expected %03h actual %03h", name, exp_pc, pc_out);
			errs++;
		end
		if (errs == 0) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d mismatches", name, errs);
		end
	endtask

	initial begin
		opcode_t alu_ops [5];
		opcode_t op;
		logic [data_w-1:0] v;
		int r;
		alu_ops = '{ADDR, SUBR, ANDR, ORR, XORR};

		clear_program();
		emit(NOP, '0);
		emit(HALT, '0);
		run_test("reset");

		// copies between addresses with the last one from the preloaded image
		clear_program();
		emit(LDI, data_w'($random(seed)));
		emit(STA, 12'h010);
		emit(LDI, data_w'($random(seed)));
		emit(STA, 12'h011);
		emit(LDA, 12'h010);
		emit(STA, 12'h020);
		emit(LDA, 12'h011);
		emit(STA, 12'h021);
		emit(LDA, 12'h300);
		emit(STA, 12'h022);
		emit(HALT, '0);
		run_test("moves");

		clear_program();
		for (int k = 0; k < 4; k++) begin
			emit(LDI, data_w'($random(seed)));
			emit(MOVR, data_w'(k));
		end
		emit(LDI, data_w'($random(seed)));
		// operand 4 wraps back to r1
		for (int k = 0; k < 5; k++) begin
			emit(alu_ops[k], data_w'(k));
			emit(STA, data_w'(12'h040 + k));
		end
		emit(INCA, '0);
		emit(STA, 12'h045);
		emit(CLRA, '0);
		emit(STA, 12'h046);
		// increment past fff wraps to zero
		emit(LDI, 12'hfff);
		emit(INCA, '0);
		emit(STA, 12'h047);
		emit(HALT, '0);
		run_test("alu");

		clear_program();
		emit(LDI, 12'h123);
		emit(STA, 12'h050);
		emit(CLRA, '0);
		// taken so the store at 4 is skipped
		emit(JZ, 12'd5);
		emit(STA, 12'h051);
		emit(LDI, 12'h0a5);
		// not taken
		emit(JZ, 12'd8);
		emit(STA, 12'h052);
		emit(JMP, 12'd11);
		emit(STA, 12'h053);
		emit(STA, 12'h054);
		emit(INCA, '0);
		emit(STA, 12'h055);
		emit(HALT, '0);
		run_test("branch");

		// nop to clra are the first twelve codes and hold no jumps
		clear_program();
		for (int k = 0; k < 40; k++) begin
			r = $unsigned($random(seed)) % 12;
			op = opcode_t'(opcode_w'(r));
			v = data_w'($random(seed));
			// low addresses so loads see earlier stores
			if (op != LDI) begin
				v = v & 12'h03f;
			end
			emit(op, v);
		end
		emit(HALT, '0);
		run_test("random");

		$display("tests: %0d ok, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+tests
source/proc_pkg.sv
source/alu.sv
source/operand_bus.sv
source/reg_file.sv
source/acc_unit.sv
source/addr_regs.sv
source/control_unit.sv
source/proc_top.sv
tests/proc_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= proc_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tests/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
